/* common/core_pkg.sv */
/*
 * Shared definitions for the multicycle load/store core:
 * data and field widths, instruction opcodes and controller states
 */
package core_pkg;

  // Data path and instruction field widths
  localparam int XLEN   = 32;
  localparam int OPC_W  = 4;
  localparam int REG_AW = 3;
  localparam int IMM_W  = 16;

  // Opcode lives in the top nibble of the instruction word
  typedef enum logic [OPC_W-1:0] {
    OP_ADDI = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_XOR  = 4'd4,
    OP_LW   = 4'd5,
    OP_SW   = 4'd6,
    OP_BEQ  = 4'd7,
    OP_HALT = 4'd15
  } opcode_e;

  // Controller sequence, one instruction in flight
  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_FETCH = 3'd1,
    ST_EXEC  = 3'd2,
    ST_MEM   = 3'd3,
    ST_WB    = 3'd4,
    ST_HALT  = 3'd5
  } ctrl_state_e;

endpackage

/* core/core_ctrl.sv */
/*
 * Core controller FSM: fetch, execute, memory access, writeback and halt
 */
`timescale 1ns/1ps

module core_ctrl (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              fetch_enable_i,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  input  core_pkg::opcode_e opcode_i,
  input  logic              branch_taken_i,
  input  logic              lsu_done_i,
  output logic              instr_req_o,
  output logic              insn_capture_o,
  output logic              lsu_start_o,
  output logic              rf_we_o,
  output logic              pc_advance_o,
  output logic              pc_branch_o,
  output logic              retire_valid_o,
  output logic              halt_o
);

  core_pkg::ctrl_state_e state_q;
  core_pkg::ctrl_state_e state_d;
  logic                  granted_q;
  logic                  is_mem;
  logic                  writes_rd;

  // Opcode classes
  always_comb begin
    is_mem    = 1'b0;
    writes_rd = 1'b0;
    case (opcode_i)
      core_pkg::OP_ADDI, core_pkg::OP_ADD, core_pkg::OP_SUB,
      core_pkg::OP_AND, core_pkg::OP_XOR: writes_rd = 1'b1;
      core_pkg::OP_LW: begin
        is_mem    = 1'b1;
        writes_rd = 1'b1;
      end
      core_pkg::OP_SW: is_mem = 1'b1;
      default: ;
    endcase
  end

  // Request held until grant, then wait for rvalid
  assign instr_req_o    = (state_q == core_pkg::ST_FETCH) && !granted_q;
  assign insn_capture_o = (state_q == core_pkg::ST_FETCH) && granted_q && instr_rvalid_i;
  assign lsu_start_o    = (state_q == core_pkg::ST_EXEC) && is_mem;
  assign rf_we_o        = (state_q == core_pkg::ST_WB) && writes_rd;
  assign pc_advance_o   = (state_q == core_pkg::ST_WB);
  assign pc_branch_o    = (state_q == core_pkg::ST_WB) &&
                          (opcode_i == core_pkg::OP_BEQ) && branch_taken_i;
  assign retire_valid_o = (state_q == core_pkg::ST_WB);
  assign halt_o         = (state_q == core_pkg::ST_HALT);

  always_comb begin
    state_d = state_q;
    case (state_q)
      core_pkg::ST_IDLE: begin
        if (fetch_enable_i) state_d = core_pkg::ST_FETCH;
      end
      core_pkg::ST_FETCH: begin
        if (insn_capture_o) state_d = core_pkg::ST_EXEC;
      end
      core_pkg::ST_EXEC: begin
        if (is_mem) state_d = core_pkg::ST_MEM;
        else        state_d = core_pkg::ST_WB;
      end
      core_pkg::ST_MEM: begin
        if (lsu_done_i) state_d = core_pkg::ST_WB;
      end
      core_pkg::ST_WB: begin
        if (opcode_i == core_pkg::OP_HALT) state_d = core_pkg::ST_HALT;
        else                               state_d = core_pkg::ST_FETCH;
      end
      core_pkg::ST_HALT: state_d = core_pkg::ST_HALT;
      default:           state_d = core_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= core_pkg::ST_IDLE;
      granted_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (instr_req_o && instr_gnt_i) begin
        granted_q <= 1'b1;
      end else if (insn_capture_o) begin
        granted_q <= 1'b0;
      end
    end
  end

endmodule

/* core/core_pc.sv */
/*
 * Program counter with boot load and branch target, plus retire count
 */
`timescale 1ns/1ps

module core_pc #(
  parameter logic [31:0] BOOT_ADDR = 32'h0000_0000
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      pc_advance_i,
  input  logic                      pc_branch_i,
  input  logic [core_pkg::XLEN-1:0] branch_offset_i,
  output logic [core_pkg::XLEN-1:0] pc_o,
  output logic [core_pkg::XLEN-1:0] instret_o
);

  logic [core_pkg::XLEN-1:0] step;

  // Taken branch adds the scaled offset instead of 4
  assign step = pc_branch_i ? branch_offset_i : core_pkg::XLEN'(4);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_o      <= BOOT_ADDR;
      instret_o <= '0;
    end else if (pc_advance_i) begin
      pc_o      <= pc_o + step;
      instret_o <= instret_o + 1'b1;
    end
  end

endmodule

/* core/core_regfile.sv */
/*
 * Eight-entry register file, two combinational reads, one write,
 * register 0 reads as zero
 */
`timescale 1ns/1ps

module core_regfile (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic [core_pkg::REG_AW-1:0] raddr_a_i,
  input  logic [core_pkg::REG_AW-1:0] raddr_b_i,
  input  logic [core_pkg::REG_AW-1:0] waddr_i,
  input  logic [core_pkg::XLEN-1:0]   wdata_i,
  input  logic                        we_i,
  output logic [core_pkg::XLEN-1:0]   rdata_a_o,
  output logic [core_pkg::XLEN-1:0]   rdata_b_o
);

  localparam int NREGS = 1 << core_pkg::REG_AW;

  logic [core_pkg::XLEN-1:0] regs_q [NREGS];

  // Entry 0 never written, so it stays at its reset value of zero
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* core/core_alu.sv */
/*
 * Instruction register, field decode and execute unit:
 * arithmetic result, memory address, branch test and offset
 */
`timescale 1ns/1ps

module core_alu (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        insn_capture_i,
  input  logic [core_pkg::XLEN-1:0]   instr_rdata_i,
  input  logic [core_pkg::XLEN-1:0]   rdata_a_i,
  input  logic [core_pkg::XLEN-1:0]   rdata_b_i,
  output logic [core_pkg::XLEN-1:0]   insn_o,
  output core_pkg::opcode_e           opcode_o,
  output logic [core_pkg::REG_AW-1:0] rs1_o,
  output logic [core_pkg::REG_AW-1:0] rs2_o,
  output logic [core_pkg::REG_AW-1:0] rd_o,
  output logic [core_pkg::XLEN-1:0]   result_o,
  output logic [core_pkg::XLEN-1:0]   mem_addr_o,
  output logic [core_pkg::XLEN-1:0]   store_data_o,
  output logic                        branch_taken_o,
  output logic [core_pkg::XLEN-1:0]   branch_offset_o
);

  // Field positions, packed downward from the opcode
  localparam int OPC_MSB = core_pkg::XLEN - 1;
  localparam int RD_MSB  = OPC_MSB - core_pkg::OPC_W;
  localparam int RS1_MSB = RD_MSB - core_pkg::REG_AW;
  localparam int RS2_MSB = RS1_MSB - core_pkg::REG_AW;

  logic [core_pkg::XLEN-1:0] insn_q;
  logic [core_pkg::XLEN-1:0] imm;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      insn_q <= '0;
    end else if (insn_capture_i) begin
      insn_q <= instr_rdata_i;
    end
  end

  assign insn_o   = insn_q;
  assign opcode_o = core_pkg::opcode_e'(insn_q[OPC_MSB -: core_pkg::OPC_W]);
  assign rd_o     = insn_q[RD_MSB -: core_pkg::REG_AW];
  assign rs1_o    = insn_q[RS1_MSB -: core_pkg::REG_AW];
  assign rs2_o    = insn_q[RS2_MSB -: core_pkg::REG_AW];

  // Sign-extended immediate
  assign imm = {{(core_pkg::XLEN - core_pkg::IMM_W){insn_q[core_pkg::IMM_W-1]}},
                insn_q[core_pkg::IMM_W-1:0]};

  always_comb begin
    case (opcode_o)
      core_pkg::OP_ADDI: result_o = rdata_a_i + imm;
      core_pkg::OP_ADD:  result_o = rdata_a_i + rdata_b_i;
      core_pkg::OP_SUB:  result_o = rdata_a_i - rdata_b_i;
      core_pkg::OP_AND:  result_o = rdata_a_i & rdata_b_i;
      core_pkg::OP_XOR:  result_o = rdata_a_i ^ rdata_b_i;
      default:           result_o = '0;
    endcase
  end

  assign mem_addr_o      = rdata_a_i + imm;
  assign store_data_o    = rdata_b_i;
  assign branch_taken_o  = (rdata_a_i == rdata_b_i);
  assign branch_offset_o = imm << 2;

endmodule

/* core/core_lsu.sv */
/*
 * Data port sequencer: holds the request until grant,
 * then waits for rvalid and keeps the load data for writeback
 */
`timescale 1ns/1ps

module core_lsu (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      start_i,
  input  logic                      we_i,
  input  logic [core_pkg::XLEN-1:0] addr_i,
  input  logic [core_pkg::XLEN-1:0] wdata_i,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  input  logic [core_pkg::XLEN-1:0] data_rdata_i,
  output logic                      data_req_o,
  output logic                      data_we_o,
  output logic [core_pkg::XLEN-1:0] data_addr_o,
  output logic [core_pkg::XLEN-1:0] data_wdata_o,
  output logic                      done_o,
  output logic [core_pkg::XLEN-1:0] load_data_o
);

  logic wait_q;

  // Request and its payload are registered so they stay stable until grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      data_req_o <= 1'b0;
      wait_q     <= 1'b0;
    end else if (start_i) begin
      data_req_o <= 1'b1;
    end else if (data_req_o && data_gnt_i) begin
      data_req_o <= 1'b0;
      wait_q     <= 1'b1;
    end else if (done_o) begin
      wait_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      data_we_o    <= we_i;
      data_addr_o  <= {addr_i[core_pkg::XLEN-1:2], 2'b00};
      data_wdata_o <= wdata_i;
    end
    if (done_o) begin
      load_data_o <= data_rdata_i;
    end
  end

  assign done_o = wait_q && data_rvalid_i;

endmodule

/* source/core_top.sv */
/*
 * Core top level: controller, program counter, register file,
 * execute unit and load/store unit with the writeback mux
 */
`timescale 1ns/1ps

module core_top #(
  parameter logic [31:0] BOOT_ADDR = 32'h0000_0000
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        fetch_enable_i,
  // Instruction port
  output logic        instr_req_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  output logic [31:0] instr_addr_o,
  input  logic [31:0] instr_rdata_i,
  // Data port
  output logic        data_req_o,
  output logic        data_we_o,
  output logic [31:0] data_addr_o,
  output logic [31:0] data_wdata_o,
  input  logic        data_gnt_i,
  input  logic        data_rvalid_i,
  input  logic [31:0] data_rdata_i,
  // Retire port
  output logic        retire_valid_o,
  output logic [31:0] retire_pc_o,
  output logic [31:0] retire_insn_o,
  output logic [2:0]  retire_rd_o,
  output logic [31:0] retire_rd_wdata_o,
  output logic        retire_rd_we_o,
  output logic        halt_o
);

  core_pkg::opcode_e               opcode;
  logic                            insn_capture;
  logic                            lsu_start;
  logic                            lsu_done;
  logic                            rf_we;
  logic                            pc_advance;
  logic                            pc_branch;
  logic                            branch_taken;
  logic [core_pkg::XLEN-1:0]       branch_offset;
  logic [core_pkg::XLEN-1:0]       pc;
  logic [core_pkg::XLEN-1:0]       insn;
  logic [core_pkg::REG_AW-1:0]     rs1;
  logic [core_pkg::REG_AW-1:0]     rs2;
  logic [core_pkg::REG_AW-1:0]     rd;
  logic [core_pkg::XLEN-1:0]       rdata_a;
  logic [core_pkg::XLEN-1:0]       rdata_b;
  logic [core_pkg::XLEN-1:0]       result;
  logic [core_pkg::XLEN-1:0]       mem_addr;
  logic [core_pkg::XLEN-1:0]       store_data;
  logic [core_pkg::XLEN-1:0]       load_data;
  logic [core_pkg::XLEN-1:0]       wb_data;

  // Writeback source: load data only when an LW is writing
  assign wb_data = (rf_we && (opcode == core_pkg::OP_LW)) ? load_data : result;

  assign instr_addr_o      = pc;
  assign retire_pc_o       = pc;
  assign retire_insn_o     = insn;
  assign retire_rd_o       = rd;
  assign retire_rd_wdata_o = wb_data;
  assign retire_rd_we_o    = rf_we && (rd != '0);

  core_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fetch_enable_i (fetch_enable_i),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .opcode_i       (opcode),
    .branch_taken_i (branch_taken),
    .lsu_done_i     (lsu_done),
    .instr_req_o    (instr_req_o),
    .insn_capture_o (insn_capture),
    .lsu_start_o    (lsu_start),
    .rf_we_o        (rf_we),
    .pc_advance_o   (pc_advance),
    .pc_branch_o    (pc_branch),
    .retire_valid_o (retire_valid_o),
    .halt_o         (halt_o)
  );

  core_pc #(
    .BOOT_ADDR (BOOT_ADDR)
  ) u_pc (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .pc_advance_i    (pc_advance),
    .pc_branch_i     (pc_branch),
    .branch_offset_i (branch_offset),
    .pc_o            (pc),
    .instret_o       ()
  );

  core_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .waddr_i   (rd),
    .wdata_i   (wb_data),
    .we_i      (rf_we),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  core_alu u_alu (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .insn_capture_i  (insn_capture),
    .instr_rdata_i   (instr_rdata_i),
    .rdata_a_i       (rdata_a),
    .rdata_b_i       (rdata_b),
    .insn_o          (insn),
    .opcode_o        (opcode),
    .rs1_o           (rs1),
    .rs2_o           (rs2),
    .rd_o            (rd),
    .result_o        (result),
    .mem_addr_o      (mem_addr),
    .store_data_o    (store_data),
    .branch_taken_o  (branch_taken),
    .branch_offset_o (branch_offset)
  );

  core_lsu u_lsu (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .start_i       (lsu_start),
    .we_i          (opcode == core_pkg::OP_SW),
    .addr_i        (mem_addr),
    .wdata_i       (store_data),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .data_req_o    (data_req_o),
    .data_we_o     (data_we_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .done_o        (lsu_done),
    .load_data_o   (load_data)
  );

endmodule

/* tests/core_tb_mem.sv */
/*
 * Behavioural memory with a request/grant/rvalid port,
 * seeded random grant and rvalid delays and a word backdoor
 */
`timescale 1ns/1ps

module core_tb_mem (
  input  logic        clk_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  max_wait_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  localparam int DEPTH = 256;

  logic [31:0] mem [DEPTH];
  integer      seed;

  // Each fill word carries its own byte address, opcode 12 is a no-op
  task automatic fill_pattern();
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 32'hc000_0000 | (i << 2);
    end
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    mem[addr[9:2]] = data;
  endtask

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    return mem[addr[9:2]];
  endfunction

  function automatic int pick_wait();
    return {$random(seed)} % (max_wait_i + 32'd1);
  endfunction

  initial begin
    seed     = 32'ha1ae322b;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    fill_pattern();
  end

  // One transaction at a time, outputs change 1 ns after the rising edge
  always begin : serve
    logic [31:0] addr;
    logic        we;
    int          n;
    @(posedge clk_i);
    #1;
    if (req_i) begin
      n = pick_wait();
      repeat (n) begin
        @(posedge clk_i);
        #1;
      end
      addr = addr_i;
      we   = we_i;
      if (we) begin
        mem[addr[9:2]] = wdata_i;
      end
      gnt_o = 1'b1;
      @(posedge clk_i);
      #1;
      gnt_o = 1'b0;
      n = pick_wait();
      repeat (n) begin
        @(posedge clk_i);
        #1;
      end
      rvalid_o = 1'b1;
      rdata_o  = we ? '0 : mem[addr[9:2]];
      @(posedge clk_i);
      #1;
      rvalid_o = 1'b0;
      rdata_o  = '0;
    end
  end

endmodule

/* tests/core_chk.sv */
/*
 * Protocol checker bound into the core: memory handshakes and halt
 */
`timescale 1ns/1ps

module core_chk (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic                  instr_req_i,
  input logic                  instr_gnt_i,
  input logic                  instr_rvalid_i,
  input logic [31:0]           instr_addr_i,
  input logic                  data_req_i,
  input logic                  data_we_i,
  input logic                  data_gnt_i,
  input logic                  data_rvalid_i,
  input logic [31:0]           data_addr_i,
  input logic [31:0]           data_wdata_i,
  input logic                  halt_i,
  input core_pkg::ctrl_state_e state_i
);

  logic instr_busy_q;
  logic data_busy_q;

  // Outstanding transaction per port, from grant until rvalid
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      instr_busy_q <= 1'b0;
      data_busy_q  <= 1'b0;
    end else begin
      if (instr_req_i && instr_gnt_i) begin
        instr_busy_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        instr_busy_q <= 1'b0;
      end
      if (data_req_i && data_gnt_i) begin
        data_busy_q <= 1'b1;
      end else if (data_rvalid_i) begin
        data_busy_q <= 1'b0;
      end
    end
  end

  instr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
    else $error("instruction request dropped or changed before grant");

  data_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_req_i && !data_gnt_i |=> data_req_i && $stable(data_addr_i) &&
    $stable(data_we_i) && $stable(data_wdata_i))
    else $error("data request dropped or changed before grant");

  instr_rvalid_owned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_rvalid_i |-> instr_busy_q)
    else $error("instruction rvalid without an outstanding request");

  data_rvalid_owned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_rvalid_i |-> data_busy_q)
    else $error("data rvalid without an outstanding request");

  halt_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    halt_i |=> halt_i)
    else $error("halt dropped before reset");

  // Data requests only while the controller waits on the data port
  data_req_in_mem: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_req_i |-> state_i == core_pkg::ST_MEM)
    else $error("data request outside the memory access state");

endmodule

bind core_top core_chk u_chk (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .instr_req_i    (instr_req_o),
  .instr_gnt_i    (instr_gnt_i),
  .instr_rvalid_i (instr_rvalid_i),
  .instr_addr_i   (instr_addr_o),
  .data_req_i     (data_req_o),
  .data_we_i      (data_we_o),
  .data_gnt_i     (data_gnt_i),
  .data_rvalid_i  (data_rvalid_i),
  .data_addr_i    (data_addr_o),
  .data_wdata_i   (data_wdata_o),
  .halt_i         (halt_o),
  .state_i        (u_ctrl.state_q)
);

/* tests/core_tb_top.sv */
/*
 * Testbench top for the multicycle core: clock, reset, memory models,
 * directed tests with a reference model and the closing summary
 */
`timescale 1ns/1ps

module core_tb_top;

  localparam logic [31:0] BOOT        = 32'h0000_0100;
  localparam int          RUN_TIMEOUT = 5000;

  logic        clk;
  logic        rst_n;
  logic        fetch_enable;
  logic [3:0]  mem_wait;
  logic        instr_req;
  logic        instr_gnt;
  logic        instr_rvalid;
  logic [31:0] instr_addr;
  logic [31:0] instr_rdata;
  logic        data_req;
  logic        data_we;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic        data_gnt;
  logic        data_rvalid;
  logic [31:0] data_rdata;
  logic        retire_valid;
  logic [31:0] retire_pc;
  logic [31:0] retire_insn;
  logic [2:0]  retire_rd;
  logic [31:0] retire_rd_wdata;
  logic        retire_rd_we;
  logic        halt;

  // Expected trace from the reference model, actual trace from the retire port
  logic [31:0]       exp_pc[$];
  logic [31:0]       exp_insn[$];
  core_pkg::opcode_e exp_op[$];
  logic [2:0]        exp_rd[$];
  logic              exp_we[$];
  logic [31:0]       exp_wdata[$];
  logic [31:0]       act_pc[$];
  logic [31:0]       act_insn[$];
  logic [2:0]        act_rd[$];
  logic              act_we[$];
  logic [31:0]       act_wdata[$];
  logic [31:0]       ref_wdata[$];
  logic [31:0]       model_rf [8];
  logic [31:0]       model_dmem [int];
  logic [31:0]       model_pc;
  logic [31:0]       ld_words [4];
  integer            seed;
  int                n_checks;
  int                n_errors;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  core_top #(
    .BOOT_ADDR (BOOT)
  ) dut0 (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .fetch_enable_i    (fetch_enable),
    .instr_req_o       (instr_req),
    .instr_gnt_i       (instr_gnt),
    .instr_rvalid_i    (instr_rvalid),
    .instr_addr_o      (instr_addr),
    .instr_rdata_i     (instr_rdata),
    .data_req_o        (data_req),
    .data_we_o         (data_we),
    .data_addr_o       (data_addr),
    .data_wdata_o      (data_wdata),
    .data_gnt_i        (data_gnt),
    .data_rvalid_i     (data_rvalid),
    .data_rdata_i      (data_rdata),
    .retire_valid_o    (retire_valid),
    .retire_pc_o       (retire_pc),
    .retire_insn_o     (retire_insn),
    .retire_rd_o       (retire_rd),
    .retire_rd_wdata_o (retire_rd_wdata),
    .retire_rd_we_o    (retire_rd_we),
    .halt_o            (halt)
  );

  core_tb_mem imem (
    .clk_i      (clk),
    .req_i      (instr_req),
    .we_i       (1'b0),
    .addr_i     (instr_addr),
    .wdata_i    (32'h0),
    .max_wait_i (mem_wait),
    .gnt_o      (instr_gnt),
    .rvalid_o   (instr_rvalid),
    .rdata_o    (instr_rdata)
  );

  core_tb_mem dmem (
    .clk_i      (clk),
    .req_i      (data_req),
    .we_i       (data_we),
    .addr_i     (data_addr),
    .wdata_i    (data_wdata),
    .max_wait_i (mem_wait),
    .gnt_o      (data_gnt),
    .rvalid_o   (data_rvalid),
    .rdata_o    (data_rdata)
  );

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("FAIL %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic check_op(input string name, input core_pkg::opcode_e exp,
                          input core_pkg::opcode_e act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("FAIL %s: expected %0d (%s), actual %0d (%s)", name, exp, exp.name(),
               act, act.name());
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic start_program();
    for (int i = 0; i < 8; i++) begin
      model_rf[i] = '0;
    end
    model_dmem.delete();
    exp_pc.delete();
    exp_insn.delete();
    exp_op.delete();
    exp_rd.delete();
    exp_we.delete();
    exp_wdata.delete();
    model_pc = BOOT;
    imem.fill_pattern();
  endtask

  // Places one instruction at the model pc and records its expected retire
  task automatic emit(input core_pkg::opcode_e op, input int rd, input int rs1, input int rs2,
                      input logic [15:0] imm);
    logic [31:0] insn;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] addr;
    logic [31:0] res;
    logic [31:0] nxt;
    logic        we;
    insn = {op, 3'(rd), 3'(rs1), 3'(rs2), 3'b000, imm};
    a    = model_rf[rs1];
    b    = model_rf[rs2];
    simm = {{16{imm[15]}}, imm};
    addr = a + simm;
    res  = '0;
    we   = 1'b0;
    nxt  = model_pc + 32'd4;
    case (op)
      core_pkg::OP_ADDI: begin
        res = a + simm;
        we  = 1'b1;
      end
      core_pkg::OP_ADD: begin
        res = a + b;
        we  = 1'b1;
      end
      core_pkg::OP_SUB: begin
        res = a - b;
        we  = 1'b1;
      end
      core_pkg::OP_AND: begin
        res = a & b;
        we  = 1'b1;
      end
      core_pkg::OP_XOR: begin
        res = a ^ b;
        we  = 1'b1;
      end
      // Programs only load words they stored earlier
      core_pkg::OP_LW: begin
        res = model_dmem.exists(int'(addr[9:2])) ? model_dmem[int'(addr[9:2])] : '0;
        we  = 1'b1;
      end
      core_pkg::OP_SW: model_dmem[int'(addr[9:2])] = b;
      core_pkg::OP_BEQ: begin
        if (a == b) nxt = model_pc + (simm << 2);
      end
      default: ;
    endcase
    if (rd == 0) we = 1'b0;
    if (we) model_rf[rd] = res;
    imem.write_word(model_pc, insn);
    exp_pc.push_back(model_pc);
    exp_insn.push_back(insn);
    exp_op.push_back(op);
    exp_rd.push_back(3'(rd));
    exp_we.push_back(we);
    exp_wdata.push_back(res);
    model_pc = nxt;
  endtask

  // Builds a full 32-bit constant from ADDI, sixteen doublings and a signed low half
  task automatic load_const(input int rd, input logic [31:0] value);
    logic [15:0] hi;
    hi = value[31:16] + {15'b0, value[15]};
    emit(core_pkg::OP_ADDI, rd, 0, 0, hi);
    repeat (16) emit(core_pkg::OP_ADD, rd, rd, rd, 16'h0000);
    emit(core_pkg::OP_ADDI, rd, rd, 0, value[15:0]);
  endtask

  task automatic run_program(input string name);
    int cycles;
    bit done;
    act_pc.delete();
    act_insn.delete();
    act_rd.delete();
    act_we.delete();
    act_wdata.delete();
    @(posedge clk);
    #1;
    fetch_enable = 1'b1;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < RUN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (retire_valid) begin
        act_pc.push_back(retire_pc);
        act_insn.push_back(retire_insn);
        act_rd.push_back(retire_rd);
        act_we.push_back(retire_rd_we);
        act_wdata.push_back(retire_rd_wdata);
        if (retire_insn[31:28] == core_pkg::OP_HALT) done = 1'b1;
      end
    end
    @(posedge clk);
    #1;
    fetch_enable = 1'b0;
    if (!done) begin
      n_errors++;
      $display("ERROR %s: HALT did not retire within %0d cycles", name, RUN_TIMEOUT);
    end
  endtask

  task automatic check_retires(input string name);
    int n;
    check_word({name, " retire count"}, exp_pc.size(), act_pc.size());
    n = (exp_pc.size() < act_pc.size()) ? exp_pc.size() : act_pc.size();
    for (int i = 0; i < n; i++) begin
      check_word($sformatf("%s pc[%0d]", name, i), exp_pc[i], act_pc[i]);
      check_word($sformatf("%s insn[%0d]", name, i), exp_insn[i], act_insn[i]);
      check_op($sformatf("%s op[%0d]", name, i), exp_op[i],
               core_pkg::opcode_e'(act_insn[i][31:28]));
      check_word($sformatf("%s rd[%0d]", name, i), 32'(exp_rd[i]), 32'(act_rd[i]));
      check_word($sformatf("%s rd_we[%0d]", name, i), 32'(exp_we[i]), 32'(act_we[i]));
      if (exp_we[i]) begin
        check_word($sformatf("%s rd_wdata[%0d]", name, i), exp_wdata[i], act_wdata[i]);
      end
    end
  endtask

  task automatic test_alu();
    apply_reset();
    start_program();
    emit(core_pkg::OP_ADDI, 1, 0, 0, 16'h1234);
    emit(core_pkg::OP_ADDI, 2, 0, 0, 16'hfffb);
    emit(core_pkg::OP_ADD, 3, 1, 2, 16'h0000);
    emit(core_pkg::OP_SUB, 4, 1, 2, 16'h0000);
    emit(core_pkg::OP_AND, 5, 1, 2, 16'h0000);
    emit(core_pkg::OP_XOR, 6, 1, 2, 16'h0000);
    emit(core_pkg::OP_ADDI, 0, 1, 0, 16'h0007);
    emit(core_pkg::OP_ADD, 7, 6, 4, 16'h0000);
    emit(core_pkg::OP_HALT, 0, 0, 0, 16'h0000);
    run_program("alu");
    check_retires("alu");
  endtask

  // Stores four random words at 0x40 and loads them back
  task automatic build_ldst();
    int k;
    start_program();
    emit(core_pkg::OP_ADDI, 7, 0, 0, 16'h0040);
    for (k = 0; k < 4; k++) begin
      load_const(1, ld_words[k]);
      emit(core_pkg::OP_SW, 0, 7, 1, 16'(4 * k));
    end
    for (k = 0; k < 4; k++) begin
      emit(core_pkg::OP_LW, 2 + k, 7, 0, 16'(4 * k));
    end
    emit(core_pkg::OP_HALT, 0, 0, 0, 16'h0000);
  endtask

  task automatic check_dmem(input string name);
    for (int k = 0; k < 4; k++) begin
      check_word($sformatf("%s dmem[%0d]", name, k), ld_words[k],
                 dmem.read_word(32'h40 + 32'(4 * k)));
    end
  endtask

  task automatic test_load_store();
    apply_reset();
    dmem.fill_pattern();
    build_ldst();
    run_program("load_store");
    check_retires("load_store");
    check_dmem("load_store");
    ref_wdata = act_wdata;
  endtask

  task automatic test_branch();
    apply_reset();
    start_program();
    emit(core_pkg::OP_ADDI, 1, 0, 0, 16'h0005);
    emit(core_pkg::OP_ADDI, 2, 0, 0, 16'h0005);
    emit(core_pkg::OP_BEQ, 0, 1, 2, 16'h0003);
    emit(core_pkg::OP_ADDI, 3, 0, 0, 16'h0001);
    emit(core_pkg::OP_BEQ, 0, 1, 3, 16'h0002);
    emit(core_pkg::OP_ADDI, 4, 0, 0, 16'h0002);
    emit(core_pkg::OP_BEQ, 0, 0, 0, 16'h0004);
    emit(core_pkg::OP_HALT, 0, 0, 0, 16'h0000);
    run_program("branch");
    check_retires("branch");
  endtask

  task automatic test_back_pressure();
    apply_reset();
    mem_wait = 4'd3;
    dmem.fill_pattern();
    build_ldst();
    run_program("back_pressure");
    check_retires("back_pressure");
    check_dmem("back_pressure");
    check_word("back_pressure same count", ref_wdata.size(), act_wdata.size());
    for (int i = 0; i < ref_wdata.size() && i < act_wdata.size(); i++) begin
      check_word($sformatf("back_pressure same wdata[%0d]", i), ref_wdata[i], act_wdata[i]);
    end
    mem_wait = 4'd0;
  endtask

  task automatic test_fetch_halt();
    int cycles;
    int bad;
    apply_reset();
    start_program();
    emit(core_pkg::OP_ADDI, 1, 0, 0, 16'h0011);
    emit(core_pkg::OP_HALT, 0, 0, 0, 16'h0000);
    bad    = 0;
    cycles = 0;
    while (cycles < 20) begin
      @(negedge clk);
      cycles++;
      if (instr_req || halt) bad++;
    end
    if (bad != 0) begin
      n_errors++;
      $display("ERROR fetch_halt: core became active while fetch enable was low");
    end
    run_program("fetch_halt");
    check_retires("fetch_halt");
    bad    = 0;
    cycles = 0;
    while (cycles < 30) begin
      @(negedge clk);
      cycles++;
      if (!halt || instr_req || data_req) bad++;
    end
    if (bad != 0) begin
      n_errors++;
      $display("ERROR fetch_halt: halt dropped or a request appeared after HALT retired");
    end
  endtask

  initial begin
    seed         = 32'ha1ae322b;
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    mem_wait     = 4'd0;
    n_checks     = 0;
    n_errors     = 0;
    for (int k = 0; k < 4; k++) begin
      ld_words[k] = $random(seed);
    end
    test_alu();
    test_load_store();
    test_branch();
    test_back_pressure();
    test_fetch_halt();
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* build.f */
common/core_pkg.sv
core/core_ctrl.sv
core/core_pc.sv
core/core_regfile.sv
core/core_alu.sv
core/core_lsu.sv
source/core_top.sv
tests/core_tb_mem.sv
tests/core_chk.sv
tests/core_tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_tb_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

FAIL_MSG := Simulation finished: FAIL
PASS_MSG := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Test failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run did not complete, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
